// ==== branch_predict_top.f ====
hw/bp_pkg.sv
hw/btb.sv
hw/fetch_pc_gen.sv
hw/branch_resolve.sv
hw/branch_predict_top.sv
verification/tb_branch_predict_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_branch_predict_top
BUILD_DIR=obj_dir

verilator --binary --assert \
    --top-module "$TOP" \
    -f branch_predict_top.f \
    --Mdir "$BUILD_DIR" \
    -o sim_"$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$("./$BUILD_DIR/sim_$TOP")
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== verification/tb_branch_predict_top.sv ====
// checks fetch and resolve traffic against a BTB model; assumes PC 0x7f00 is never fetched by a walk
`timescale 1ns/1ps

module tb_branch_predict_top;

    import bp_pkg::*;

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] SEED       = 32'h3993;
    localparam pc_t         SCRATCH_PC = 32'h0000_7f00;  // steering branch, index 32
    localparam pc_t         BR_A       = 32'h0000_1040;  // slot 0 branch
    localparam pc_t         BR_C       = 32'h0000_1084;  // slot 1 branch
    localparam pc_t         BR_D       = 32'h0000_1284;  // same index as BR_C
    localparam pc_t         TGT_0      = 32'h0000_1400;
    localparam pc_t         TGT_1      = 32'h0000_1600;
    localparam pc_t         TGT_2      = 32'h0000_1800;
    localparam pc_t         TGT_3      = 32'h0000_1a00;

    logic       clk                 = 1'b0;
    logic       rst                 = 1'b1;
    logic       fetch_ready         = 1'b0;
    logic       resolve_valid       = 1'b0;
    pc_t        resolve_pc          = '0;
    logic       resolve_taken       = 1'b0;
    pc_t        resolve_target      = '0;
    logic       resolve_pred_taken  = 1'b0;
    pc_t        resolve_pred_target = '0;

    logic       fetch_valid;
    pc_t        fetch_pc;
    slot_mask_t fetch_pred_taken;
    pc_t        fetch_pred_target;
    logic       resolve_ready;
    cnt_t       misp_count;

    logic [1:0]  ready_mode = 2'd0;  // 0 low, 1 high, 2 random
    logic [31:0] rng_ready  = SEED;
    logic [31:0] rng_pc     = SEED;

    // reference BTB and expected fetch stream
    btb_tag_t                m_tag    [1<<INDEX_W];
    slot_mask_t              m_mask   [1<<INDEX_W];
    pc_t                     m_target [1<<INDEX_W];
    logic [(1<<INDEX_W)-1:0] m_valid;
    logic       exp_valid;
    pc_t        exp_pc;
    logic       booting;
    cnt_t       exp_misp;
    logic       pend_valid;
    pc_t        pend_pc;
    logic       pend_taken;
    pc_t        pend_target;
    btb_index_t exp_idx;
    logic       exp_hit;
    slot_mask_t exp_pred;
    pc_t        exp_target;

    logic       hold_chk;
    pc_t        held_pc;
    slot_mask_t held_pred;
    pc_t        held_target;

    int err_fetch   = 0;
    int err_pred    = 0;
    int err_misp    = 0;
    int err_hold    = 0;
    int err_reset   = 0;
    int n_timeout   = 0;

    always #5 clk = ~clk;

    branch_predict_top i_branch_predict_top (
        .clk                 (clk),
        .rst                 (rst),
        .fetch_valid         (fetch_valid),
        .fetch_ready         (fetch_ready),
        .fetch_pc            (fetch_pc),
        .fetch_pred_taken    (fetch_pred_taken),
        .fetch_pred_target   (fetch_pred_target),
        .resolve_valid       (resolve_valid),
        .resolve_ready       (resolve_ready),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .misp_count          (misp_count)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic slot_mask_t slot_taken_mask(input pc_t pc, input logic taken);
        if (!taken) begin
            return 2'b00;
        end
        return pc[OFFSET_W-1] ? 2'b10 : 2'b01;
    endfunction

    function automatic logic is_failure(input logic taken, input logic pred,
                                        input pc_t target, input pc_t pred_target);
        return (taken != pred) || (taken && pred && (target != pred_target));
    endfunction

    always @(posedge clk) begin
        rng_ready = next_random(rng_ready);
        case (ready_mode)
            2'd0:    fetch_ready <= 1'b0;
            2'd1:    fetch_ready <= 1'b1;
            default: fetch_ready <= rng_ready[0] | rng_ready[1];  // mostly ready
        endcase
    end

    assign exp_idx    = exp_pc[INDEX_LSB +: INDEX_W];
    assign exp_hit    = m_valid[exp_idx] && (m_tag[exp_idx] == exp_pc[TAG_LSB +: TAG_W]);
    assign exp_target = m_target[exp_idx];
    assign exp_pred   = !exp_hit ? 2'b00
                      : (exp_pc[OFFSET_W-1] ? {m_mask[exp_idx][1], 1'b0} : m_mask[exp_idx]);

    always @(posedge clk) begin
        if (rst) begin
            m_valid    <= '0;
            exp_valid  <= 1'b0;
            exp_pc     <= RESET_PC;
            booting    <= 1'b1;
            exp_misp   <= '0;
            pend_valid <= 1'b0;
        end else begin
            booting <= 1'b0;
            if (pend_valid) begin  // table write and redirect one edge after acceptance
                m_valid[pend_pc[INDEX_LSB +: INDEX_W]]  <= 1'b1;
                m_tag[pend_pc[INDEX_LSB +: INDEX_W]]    <= pend_pc[TAG_LSB +: TAG_W];
                m_mask[pend_pc[INDEX_LSB +: INDEX_W]]   <= slot_taken_mask(pend_pc, pend_taken);
                m_target[pend_pc[INDEX_LSB +: INDEX_W]] <= pend_target;
                exp_misp  <= exp_misp + cnt_t'(1);
                exp_pc    <= pend_taken ? pend_target : pend_pc + pc_t'(INSN_BYTES);
                exp_valid <= 1'b1;
            end else if (booting) begin
                exp_valid <= 1'b1;
                exp_pc    <= RESET_PC;
            end else if (exp_valid && fetch_ready) begin
                exp_pc <= (exp_pred != 2'b00) ? exp_target
                        : {exp_pc[PC_W-1:OFFSET_W], {OFFSET_W{1'b0}}} + pc_t'(PACKET_BYTES);
            end
            pend_valid  <= resolve_valid && is_failure(resolve_taken, resolve_pred_taken,
                                                       resolve_target, resolve_pred_target);
            pend_pc     <= resolve_pc;
            pend_taken  <= resolve_taken;
            pend_target <= resolve_target;
        end
    end

    // an offered item that is not taken must stay put
    always @(posedge clk) begin
        hold_chk    <= !rst && fetch_valid && !fetch_ready && !pend_valid;
        held_pc     <= fetch_pc;
        held_pred   <= fetch_pred_taken;
        held_target <= fetch_pred_target;
    end

    reset_clears: assert property (@(negedge clk)
        rst |-> (!fetch_valid && (misp_count == '0)))
    else begin
        err_reset = err_reset + 1;
        $display("[ERROR] %0t fetch_valid or misp_count not clear in reset", $time);
    end

    valid_matches: assert property (@(negedge clk) disable iff (rst) fetch_valid == exp_valid)
    else begin
        err_fetch = err_fetch + 1;
        $display("[ERROR] %0t fetch_valid %b, expected %b", $time, fetch_valid, exp_valid);
    end

    pc_matches: assert property (@(negedge clk) disable iff (rst)
        fetch_valid |-> (fetch_pc == exp_pc))
    else begin
        err_fetch = err_fetch + 1;
        $display("[ERROR] %0t fetch_pc %h, expected %h", $time, fetch_pc, exp_pc);
    end

    pred_matches: assert property (@(negedge clk) disable iff (rst)
        fetch_valid |-> (fetch_pred_taken == exp_pred))
    else begin
        err_pred = err_pred + 1;
        $display("[ERROR] %0t pc %h pred_taken %b, expected %b", $time, fetch_pc,
                 fetch_pred_taken, exp_pred);
    end

    target_matches: assert property (@(negedge clk) disable iff (rst)
        (fetch_valid && exp_hit) |-> (fetch_pred_target == exp_target))
    else begin
        err_pred = err_pred + 1;
        $display("[ERROR] %0t pred_target %h, expected %h", $time, fetch_pred_target,
                 exp_target);
    end

    misp_matches: assert property (@(negedge clk) disable iff (rst) misp_count == exp_misp)
    else begin
        err_misp = err_misp + 1;
        $display("[ERROR] %0t misp_count %0d, expected %0d", $time, misp_count, exp_misp);
    end

    held_stable: assert property (@(negedge clk) disable iff (rst)
        hold_chk |-> (fetch_valid && (fetch_pc == held_pc) && (fetch_pred_taken == held_pred)
                      && (fetch_pred_target == held_target)))
    else begin
        err_hold = err_hold + 1;
        $display("[ERROR] %0t stalled item changed, pc %h was %h", $time, fetch_pc, held_pc);
    end

    ready_high: assert property (@(negedge clk) disable iff (rst) resolve_ready)
    else begin
        err_fetch = err_fetch + 1;
        $display("[ERROR] %0t resolve_ready low", $time);
    end

    task automatic wait_for_fetch_pc(input pc_t pc);
        int   n;
        logic found;
        n     = 0;
        found = 1'b0;
        while (!found && n < WAIT_LIMIT) begin
            @(negedge clk);
            n = n + 1;
            found = fetch_valid && (fetch_pc == pc);
        end
        if (!found) begin
            n_timeout = n_timeout + 1;
            $display("timeout: fetch never offered pc %h within %0d cycles", pc, WAIT_LIMIT);
        end
    endtask

    task automatic wait_for_transfers(input int count);
        int seen;
        int n;
        seen = 0;
        n    = 0;
        while (seen < count && n < WAIT_LIMIT) begin
            @(negedge clk);
            n = n + 1;
            if (fetch_valid && fetch_ready) begin
                seen = seen + 1;
            end
        end
        if (seen < count) begin
            n_timeout = n_timeout + 1;
            $display("timeout: only %0d of %0d fetch items were taken", seen, count);
        end
    endtask

    // returns just before the accepting edge so that calls can run back to back
    task automatic send_resolve(input pc_t pc, input logic taken, input pc_t target,
                                input logic pred, input pc_t pred_target);
        int n;
        n = 0;
        @(posedge clk);
        resolve_valid       <= 1'b1;
        resolve_pc          <= pc;
        resolve_taken       <= taken;
        resolve_target      <= target;
        resolve_pred_taken  <= pred;
        resolve_pred_target <= pred_target;
        @(negedge clk);
        while (!resolve_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n = n + 1;
        end
        if (!resolve_ready) begin
            n_timeout = n_timeout + 1;
            $display("timeout: resolve_ready never came for pc %h", pc);
        end
    endtask

    task automatic end_resolve();
        @(posedge clk);
        resolve_valid <= 1'b0;
    endtask

    task automatic steer_fetch(input pc_t dest);
        send_resolve(SCRATCH_PC, 1'b1, dest, 1'b0, '0);
        end_resolve();
    endtask

    initial begin
        pc_t r_pc;
        pc_t r_tgt;
        int  total;
        repeat (10) @(posedge clk);
        rst        <= 1'b0;
        ready_mode <= 2'd1;
        wait_for_transfers(8);  // empty table, sequential packets
        @(posedge clk);
        ready_mode <= 2'd0;
        repeat (6) @(posedge clk);
        ready_mode <= 2'd2;
        repeat (40) @(posedge clk);

        send_resolve(BR_A, 1'b1, TGT_0, 1'b0, '0);
        end_resolve();
        wait_for_fetch_pc(TGT_0);
        steer_fetch(BR_A);
        wait_for_fetch_pc(BR_A);
        wait_for_fetch_pc(TGT_0);

        // slot 0 entry seen from slot 1
        steer_fetch(BR_A + pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_A + pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_A + pc_t'(PACKET_BYTES));

        send_resolve(BR_C, 1'b1, TGT_1, 1'b0, '0);
        end_resolve();
        wait_for_fetch_pc(TGT_1);
        steer_fetch(BR_C - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_C - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(TGT_1);
        steer_fetch(BR_C);
        wait_for_fetch_pc(BR_C);
        wait_for_fetch_pc(TGT_1);

        send_resolve(BR_A, 1'b1, TGT_0, 1'b1, TGT_0);  // correct, no redirect
        end_resolve();
        repeat (5) @(posedge clk);
        send_resolve(BR_A, 1'b0, TGT_0, 1'b1, TGT_0);
        end_resolve();
        wait_for_fetch_pc(BR_A + pc_t'(INSN_BYTES));
        steer_fetch(BR_A);
        wait_for_fetch_pc(BR_A);
        wait_for_fetch_pc(BR_A + pc_t'(PACKET_BYTES));
        send_resolve(BR_C, 1'b1, TGT_2, 1'b1, TGT_1);  // wrong target
        end_resolve();
        wait_for_fetch_pc(TGT_2);
        steer_fetch(BR_C - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_C - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(TGT_2);

        steer_fetch(BR_D - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_D - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_D + pc_t'(INSN_BYTES));  // tag mismatch, sequential
        send_resolve(BR_D, 1'b1, TGT_3, 1'b0, '0);
        end_resolve();
        wait_for_fetch_pc(TGT_3);
        steer_fetch(BR_C - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_C - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_C + pc_t'(INSN_BYTES));
        steer_fetch(BR_D - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(BR_D - pc_t'(INSN_BYTES));
        wait_for_fetch_pc(TGT_3);

        // back to back resolutions with random outcomes
        for (int i = 0; i < 12; i++) begin
            rng_pc = next_random(rng_pc);
            r_pc   = pc_t'(32'h0000_1000) + (rng_pc & 32'h0000_0ffc);
            rng_pc = next_random(rng_pc);
            r_tgt  = pc_t'(32'h0000_1000) + (rng_pc & 32'h0000_0ffc);
            send_resolve(r_pc, rng_pc[16], r_tgt, rng_pc[17],
                         rng_pc[18] ? r_tgt : r_tgt + pc_t'(PACKET_BYTES));
        end
        end_resolve();
        repeat (60) @(posedge clk);

        total = err_fetch + err_pred + err_misp + err_hold + err_reset + n_timeout;
        $display("errors: fetch %0d, prediction %0d, count %0d, hold %0d, reset %0d, timeouts %0d",
                 err_fetch, err_pred, err_misp, err_hold, err_reset, n_timeout);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== hw/branch_predict_top.sv ====
// branch prediction front end; only fetch_ready back-pressures, resolutions are always accepted
`timescale 1ns/1ps

module branch_predict_top (
    input  logic               clk,
    input  logic               rst,

    // fetch consumer
    output logic               fetch_valid,
    input  logic               fetch_ready,
    output bp_pkg::pc_t        fetch_pc,
    output bp_pkg::slot_mask_t fetch_pred_taken,
    output bp_pkg::pc_t        fetch_pred_target,

    // execute stage
    input  logic               resolve_valid,
    output logic               resolve_ready,
    input  bp_pkg::pc_t        resolve_pc,
    input  logic               resolve_taken,
    input  bp_pkg::pc_t        resolve_target,
    input  logic               resolve_pred_taken,
    input  bp_pkg::pc_t        resolve_pred_target,

    output bp_pkg::cnt_t       misp_count
);

    import bp_pkg::*;

    pc_t        lookup_pc;
    logic       lookup_hit;
    slot_mask_t lookup_taken;
    pc_t        lookup_target;

    logic       upd_valid;
    pc_t        upd_pc;
    logic       upd_taken;
    pc_t        upd_target;

    logic       redirect_valid;
    pc_t        redirect_pc;

    btb i_btb (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc     (lookup_pc),
        .lookup_hit    (lookup_hit),
        .lookup_taken  (lookup_taken),
        .lookup_target (lookup_target),
        .upd_valid     (upd_valid),
        .upd_pc        (upd_pc),
        .upd_taken     (upd_taken),
        .upd_target    (upd_target)
    );

    fetch_pc_gen i_fetch_pc_gen (
        .clk               (clk),
        .rst               (rst),
        .fetch_valid       (fetch_valid),
        .fetch_ready       (fetch_ready),
        .fetch_pc          (fetch_pc),
        .fetch_pred_taken  (fetch_pred_taken),
        .fetch_pred_target (fetch_pred_target),
        .lookup_pc         (lookup_pc),
        .lookup_hit        (lookup_hit),
        .lookup_taken      (lookup_taken),
        .lookup_target     (lookup_target),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

    branch_resolve i_branch_resolve (
        .clk                 (clk),
        .rst                 (rst),
        .resolve_valid       (resolve_valid),
        .resolve_ready       (resolve_ready),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .upd_valid           (upd_valid),
        .upd_pc              (upd_pc),
        .upd_taken           (upd_taken),
        .upd_target          (upd_target),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc),
        .misp_count          (misp_count)
    );

endmodule

// ==== hw/branch_resolve.sv ====
// resolution stage; never stalls, so resolve_ready is tied high and one update can be in flight
`timescale 1ns/1ps

module branch_resolve (
    input  logic         clk,
    input  logic         rst,

    // resolved branch from execute
    input  logic         resolve_valid,
    output logic         resolve_ready,
    input  bp_pkg::pc_t  resolve_pc,
    input  logic         resolve_taken,
    input  bp_pkg::pc_t  resolve_target,
    input  logic         resolve_pred_taken,
    input  bp_pkg::pc_t  resolve_pred_target,

    // BTB rewrite
    output logic         upd_valid,
    output bp_pkg::pc_t  upd_pc,
    output logic         upd_taken,
    output bp_pkg::pc_t  upd_target,

    // fetch redirect
    output logic         redirect_valid,
    output bp_pkg::pc_t  redirect_pc,

    output bp_pkg::cnt_t misp_count
);

    import bp_pkg::*;

    logic accept;
    logic dir_fail;
    logic tgt_fail;
    logic fail;
    pc_t  redirect_pc_d;

    logic upd_valid_q;
    pc_t  upd_pc_q;
    logic upd_taken_q;
    pc_t  upd_target_q;
    pc_t  redirect_pc_q;
    cnt_t misp_q;

    assign resolve_ready = 1'b1;
    assign accept        = resolve_valid && resolve_ready;

    // failure detection
    assign dir_fail = (resolve_taken != resolve_pred_taken);
    assign tgt_fail = resolve_taken && resolve_pred_taken
                      && (resolve_target != resolve_pred_target);
    assign fail     = accept && (dir_fail || tgt_fail);

    assign redirect_pc_d = resolve_taken ? resolve_target
                                         : resolve_pc + pc_t'(INSN_BYTES);  // fall through

    always_ff @(posedge clk) begin
        if (rst) begin
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= fail;  // single-cycle pulse per failure
        end
    end

    always_ff @(posedge clk) begin
        if (fail) begin
            upd_pc_q      <= resolve_pc;
            upd_taken_q   <= resolve_taken;
            upd_target_q  <= resolve_target;
            redirect_pc_q <= redirect_pc_d;
        end
    end

    // counts at the same edge the table is written
    always_ff @(posedge clk) begin
        if (rst) begin
            misp_q <= '0;
        end else if (upd_valid_q) begin
            misp_q <= misp_q + cnt_t'(1);  // wraps
        end
    end

    assign upd_valid      = upd_valid_q;
    assign upd_pc         = upd_pc_q;
    assign upd_taken      = upd_taken_q;
    assign upd_target     = upd_target_q;
    assign redirect_valid = upd_valid_q;
    assign redirect_pc    = redirect_pc_q;
    assign misp_count     = misp_q;

endmodule

// ==== hw/fetch_pc_gen.sv ====
// fetch PC sequencer; a redirect always wins and drops the item on offer, one idle cycle after reset
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic               clk,
    input  logic               rst,

    // fetch item to the consumer
    output logic               fetch_valid,
    input  logic               fetch_ready,
    output bp_pkg::pc_t        fetch_pc,
    output bp_pkg::slot_mask_t fetch_pred_taken,
    output bp_pkg::pc_t        fetch_pred_target,

    // BTB lookup
    output bp_pkg::pc_t        lookup_pc,
    input  logic               lookup_hit,
    input  bp_pkg::slot_mask_t lookup_taken,
    input  bp_pkg::pc_t        lookup_target,

    // redirect pulse from resolution
    input  logic               redirect_valid,
    input  bp_pkg::pc_t        redirect_pc
);

    import bp_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    pc_t          pc_q;
    pc_t          pc_d;

    logic         xfer;
    logic         pred_taken;
    pc_t          seq_pc;

    assign fetch_valid       = (state_q == FG_FETCH);
    assign fetch_pc          = pc_q;
    assign lookup_pc         = pc_q;
    assign fetch_pred_taken  = lookup_hit ? lookup_taken : 2'b00;  // miss predicts nothing
    assign fetch_pred_target = lookup_target;

    assign xfer       = fetch_valid && fetch_ready;
    assign pred_taken = lookup_hit && (lookup_taken != 2'b00);
    assign seq_pc     = {pc_q[PC_W-1:OFFSET_W], {OFFSET_W{1'b0}}} + pc_t'(PACKET_BYTES);

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            FG_BOOT: begin
                state_d = FG_FETCH;
                pc_d    = RESET_PC;
            end
            FG_FETCH: begin
                if (xfer) begin
                    pc_d = pred_taken ? lookup_target : seq_pc;
                end
            end
            default: begin
                state_d = FG_BOOT;
            end
        endcase
        if (redirect_valid) begin  // outranks any pending transfer
            state_d = FG_FETCH;
            pc_d    = redirect_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FG_BOOT;
            pc_q    <= RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

endmodule

// ==== hw/btb.sv ====
// direct-mapped BTB with 64 entries and no associativity; PCs sharing an index and tag alias
`timescale 1ns/1ps

module btb (
    input  logic               clk,
    input  logic               rst,

    // lookup side, combinational
    input  bp_pkg::pc_t        lookup_pc,
    output logic               lookup_hit,
    output bp_pkg::slot_mask_t lookup_taken,
    output bp_pkg::pc_t        lookup_target,

    // update side, written on the next edge
    input  logic               upd_valid,
    input  bp_pkg::pc_t        upd_pc,
    input  logic               upd_taken,
    input  bp_pkg::pc_t        upd_target
);

    import bp_pkg::*;

    // entry storage
    btb_tag_t   tag_mem    [1<<INDEX_W];
    slot_mask_t mask_mem   [1<<INDEX_W];
    pc_t        target_mem [1<<INDEX_W];

    logic [(1<<INDEX_W)-1:0] valid_q;

    btb_index_t lk_index;
    btb_tag_t   lk_tag;
    slot_mask_t rd_mask;

    btb_index_t upd_index;
    btb_tag_t   upd_tag;
    slot_mask_t wr_mask;

    // address split
    assign lk_index  = lookup_pc[INDEX_LSB +: INDEX_W];
    assign lk_tag    = lookup_pc[TAG_LSB +: TAG_W];
    assign upd_index = upd_pc[INDEX_LSB +: INDEX_W];
    assign upd_tag   = upd_pc[TAG_LSB +: TAG_W];

    // lookup
    assign rd_mask       = mask_mem[lk_index];
    assign lookup_hit    = valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);
    assign lookup_target = target_mem[lk_index];

    always_comb begin
        if (lookup_pc[OFFSET_W-1]) begin
            lookup_taken = {rd_mask[1], 1'b0};  // started in slot 1, drop slot 0
        end else begin
            lookup_taken = rd_mask;
        end
    end

    // the resolved slot decides which mask bit is set
    always_comb begin
        if (!upd_taken) begin
            wr_mask = 2'b00;
        end else if (upd_pc[OFFSET_W-1]) begin
            wr_mask = 2'b10;
        end else begin
            wr_mask = 2'b01;
        end
    end

    // whole entry rewritten on every update
    always_ff @(posedge clk) begin
        if (upd_valid) begin
            tag_mem[upd_index]    <= upd_tag;
            mask_mem[upd_index]   <= wr_mask;
            target_mem[upd_index] <= upd_target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_valid) begin
            valid_q[upd_index] <= 1'b1;
        end
    end

endmodule

// ==== hw/bp_pkg.sv ====
// widths, address split and types for the two-wide fetch predictor; tags cover PC bits 16:9 only
package bp_pkg;

    // address split: [2:0] byte offset, [8:3] index, [16:9] tag, upper bits ignored
    localparam int PC_W         = 32;
    localparam int INDEX_W      = 6;  // 64 entries
    localparam int TAG_W        = 8;
    localparam int OFFSET_W     = 3;
    localparam int INDEX_LSB    = 3;
    localparam int TAG_LSB      = 9;

    // fetch packet geometry
    localparam int PACKET_BYTES = 8;  // two slots per packet
    localparam int INSN_BYTES   = 4;

    localparam logic [PC_W-1:0] RESET_PC = 32'h0000_1000;

    localparam int CNT_W        = 16;

    typedef logic [PC_W-1:0]    pc_t;
    typedef logic [INDEX_W-1:0] btb_index_t;
    typedef logic [TAG_W-1:0]   btb_tag_t;

    // bit n set means slot n holds a taken branch
    typedef logic [1:0]         slot_mask_t;

    typedef logic [CNT_W-1:0]   cnt_t;

    typedef enum logic [0:0] {
        FG_BOOT,
        FG_FETCH
    } fetch_state_t;

endpackage
